/* include/proc_cfg.svh */
`ifndef PROC_CFG_SVH
`define PROC_CFG_SVH

// data path and instruction word width
`define PROC_DATA_W 16

// instruction memory size in words
`define PROC_IMEM_DEPTH 256

// data memory size in words
`define PROC_DMEM_DEPTH 256

// general register count
`define PROC_REG_CNT 8

`endif

/* hw/isaPkg.sv */
`default_nettype none

package isaPkg;

  // primary opcodes, bits 15..11
  // register ALU ops share the top bits so the low two bits pick the ALU op
  typedef enum logic [4:0] {
    OP_HALT = 5'b00000,
    OP_J    = 5'b00100,
    OP_ADDI = 5'b01000,
    OP_BEQZ = 5'b01100,
    OP_ST   = 5'b10000,
    OP_LD   = 5'b10001,
    OP_ADD  = 5'b11000,
    OP_SUB  = 5'b11001,
    OP_AND  = 5'b11010,
    OP_XOR  = 5'b11011
  } opcode_e;

  // low field holds rd in bits 4..2 or imm5
  typedef struct packed {
    opcode_e    opcode;
    logic [2:0] rs;
    logic [2:0] rt;
    logic [4:0] low;
  } instr_t;

  typedef enum logic [1:0] {
    ALU_ADD = 2'b00,
    ALU_SUB = 2'b01,
    ALU_AND = 2'b10,
    ALU_XOR = 2'b11
  } aluOp_e;

endpackage

`default_nettype wire

/* hw/pipePkg.sv */
`default_nettype none

`include "proc_cfg.svh"

package pipePkg;

  typedef logic [2:0] dest_t;

  typedef struct packed {
    logic           regWrite;
    logic           memRead;
    logic           memWrite;
    logic           isBranch;
    logic           isJump;
    logic           useImm;
    isaPkg::aluOp_e aluOp;
    logic           isHalt;
    logic           isErr;
  } ctrl_t;

  // pc is the fetch address plus one
  typedef struct packed {
    logic                    valid;
    logic [`PROC_DATA_W-1:0] pc;
    isaPkg::instr_t          instr;
  } ifId_t;

  typedef struct packed {
    logic                    valid;
    ctrl_t                   ctrl;
    logic [`PROC_DATA_W-1:0] pc;
    logic [`PROC_DATA_W-1:0] a;
    logic [`PROC_DATA_W-1:0] b;
    logic [`PROC_DATA_W-1:0] imm;
    dest_t                   dest;
  } idEx_t;

  typedef struct packed {
    logic                    valid;
    ctrl_t                   ctrl;
    logic [`PROC_DATA_W-1:0] result;
    logic [`PROC_DATA_W-1:0] storeData;
    dest_t                   dest;
  } exMem_t;

  typedef struct packed {
    logic                    valid;
    ctrl_t                   ctrl;
    logic [`PROC_DATA_W-1:0] result;
    logic [`PROC_DATA_W-1:0] loadData;
    dest_t                   dest;
  } memWb_t;

  // single cycle pulse from execute
  typedef struct packed {
    logic                    taken;
    logic [`PROC_DATA_W-1:0] target;
  } redirect_t;

  typedef struct packed {
    dest_t rs;
    dest_t rt;
    logic  useRs;
    logic  useRt;
  } srcUse_t;

  // writeback observation
  typedef struct packed {
    logic                    valid;
    dest_t                   regIdx;
    logic [`PROC_DATA_W-1:0] data;
  } regWrite_t;

  // store observation
  typedef struct packed {
    logic                    valid;
    logic [`PROC_DATA_W-1:0] addr;
    logic [`PROC_DATA_W-1:0] data;
  } memWrite_t;

endpackage

`default_nettype wire

/* hw/fetchStage.sv */
`default_nettype none

`include "proc_cfg.svh"

module fetchStage (
  input  logic                                 clk,
  input  logic                                 arstN,
  input  logic                                 imemWe,
  input  logic [$clog2(`PROC_IMEM_DEPTH)-1:0]  imemAddr,
  input  isaPkg::instr_t                       imemData,
  input  logic                                 stall,
  input  pipePkg::redirect_t                   redirect,
  input  logic                                 halted,
  output pipePkg::ifId_t                       ifId
);
  import isaPkg::*;

  localparam int imemAw = $clog2(`PROC_IMEM_DEPTH);

  instr_t                  imem [`PROC_IMEM_DEPTH];
  logic [`PROC_DATA_W-1:0] pc;
  logic [`PROC_DATA_W-1:0] pcNext;

  // program load port, only used while the core is in reset
  always_ff @(posedge clk) begin
    if (imemWe) begin
      imem[imemAddr] <= imemData;
    end
  end

  assign pcNext = pc + 1'b1;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc   <= '0;
      ifId <= '0;
    end else if (redirect.taken) begin
      // the word fetched this cycle is on the wrong path
      pc         <= redirect.target;
      ifId.valid <= 1'b0;
    end else if (!stall && !halted) begin
      pc         <= pcNext;
      ifId.valid <= 1'b1;
      ifId.pc    <= pcNext;
      ifId.instr <= imem[pc[imemAw-1:0]];
    end
  end

endmodule

`default_nettype wire

/* hw/decodeStage.sv */
`default_nettype none

`include "proc_cfg.svh"

module decodeStage (
  input  logic                clk,
  input  logic                arstN,
  input  pipePkg::ifId_t      ifId,
  input  pipePkg::memWb_t     memWb,
  input  logic                stall,
  input  pipePkg::redirect_t  redirect,
  output pipePkg::idEx_t      idEx,
  output pipePkg::srcUse_t    srcUse,
  output pipePkg::regWrite_t  wbOut,
  output logic                halted,
  output logic                err
);
  import isaPkg::*;
  import pipePkg::*;

  instr_t                  instr;
  ctrl_t                   ctrl;
  dest_t                   dest;
  logic [`PROC_DATA_W-1:0] imm;
  logic                    useRs;
  logic                    useRt;
  logic [`PROC_DATA_W-1:0] regs [`PROC_REG_CNT];
  logic [`PROC_DATA_W-1:0] wbData;
  logic [`PROC_DATA_W-1:0] rdA;
  logic [`PROC_DATA_W-1:0] rdB;
  logic                    issue;
  logic                    haltIssued;
  logic                    haltSeen;
  logic                    errSeen;
  logic                    wbHalt;

  assign instr = ifId.instr;

  always_comb begin
    ctrl  = '0;
    imm   = '0;
    dest  = instr.low[4:2];
    useRs = 1'b0;
    useRt = 1'b0;
    case (instr.opcode)
      OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
        ctrl.regWrite = 1'b1;
        // low opcode bits line up with the ALU op encoding
        ctrl.aluOp    = aluOp_e'(instr.opcode[1:0]);
        useRs         = 1'b1;
        useRt         = 1'b1;
      end
      OP_ADDI, OP_LD: begin
        ctrl.regWrite = 1'b1;
        ctrl.memRead  = (instr.opcode == OP_LD);
        ctrl.useImm   = 1'b1;
        imm           = {{11{instr.low[4]}}, instr.low};
        dest          = instr.rt;
        useRs         = 1'b1;
      end
      OP_ST: begin
        ctrl.memWrite = 1'b1;
        ctrl.useImm   = 1'b1;
        imm           = {{11{instr.low[4]}}, instr.low};
        useRs         = 1'b1;
        useRt         = 1'b1;
      end
      OP_BEQZ: begin
        ctrl.isBranch = 1'b1;
        imm           = {{8{instr.rt[2]}}, instr.rt, instr.low};
        useRs         = 1'b1;
      end
      OP_J: begin
        ctrl.isJump = 1'b1;
        imm         = {{5{instr.rs[2]}}, instr.rs, instr.rt, instr.low};
      end
      OP_HALT: ctrl.isHalt = 1'b1;
      default: ctrl.isErr = 1'b1;
    endcase
  end

  assign srcUse.rs    = instr.rs;
  assign srcUse.rt    = instr.rt;
  assign srcUse.useRs = ifId.valid & useRs;
  assign srcUse.useRt = ifId.valid & useRt;

  // writeback select and observation
  assign wbData       = memWb.ctrl.memRead ? memWb.loadData : memWb.result;
  assign wbOut.valid  = memWb.valid & memWb.ctrl.regWrite;
  assign wbOut.regIdx = memWb.dest;
  assign wbOut.data   = wbData;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `PROC_REG_CNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wbOut.valid) begin
      regs[wbOut.regIdx] <= wbData;
    end
  end

  // write before read in the same cycle
  assign rdA = (wbOut.valid && wbOut.regIdx == instr.rs) ? wbData : regs[instr.rs];
  assign rdB = (wbOut.valid && wbOut.regIdx == instr.rt) ? wbData : regs[instr.rt];

  // nothing younger than an issued halt enters execute
  assign issue = ifId.valid & ~stall & ~redirect.taken & ~haltIssued;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      idEx       <= '0;
      haltIssued <= 1'b0;
    end else begin
      idEx.valid <= issue;
      idEx.ctrl  <= issue ? ctrl : '0;
      idEx.pc    <= ifId.pc;
      idEx.a     <= rdA;
      idEx.b     <= rdB;
      idEx.imm   <= imm;
      idEx.dest  <= dest;
      if (issue && (ctrl.isHalt || ctrl.isErr)) begin
        haltIssued <= 1'b1;
      end
    end
  end

  assign wbHalt = memWb.valid & (memWb.ctrl.isHalt | memWb.ctrl.isErr);

  // sticky halt and error status
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      haltSeen <= 1'b0;
      errSeen  <= 1'b0;
    end else begin
      if (wbHalt) begin
        haltSeen <= 1'b1;
      end
      if (memWb.valid && memWb.ctrl.isErr) begin
        errSeen <= 1'b1;
      end
    end
  end

  assign halted = haltSeen | wbHalt;
  assign err    = errSeen | (memWb.valid & memWb.ctrl.isErr);

endmodule

`default_nettype wire

/* hw/hazardDetect.sv */
`default_nettype none

module hazardDetect (
  input  pipePkg::srcUse_t srcUse,
  input  pipePkg::idEx_t   idEx,
  input  pipePkg::exMem_t  exMem,
  output logic             stall
);
  import pipePkg::*;

  logic exHit;
  logic memHit;

  // true when a used source reads register d
  function automatic logic readsReg(srcUse_t s, dest_t d);
    return (s.useRs && s.rs == d) || (s.useRt && s.rt == d);
  endfunction

  // producer still in execute
  assign exHit  = idEx.valid & idEx.ctrl.regWrite & readsReg(srcUse, idEx.dest);

  // producer in memory, register file catches it one cycle later
  assign memHit = exMem.valid & exMem.ctrl.regWrite & readsReg(srcUse, exMem.dest);

  assign stall = exHit | memHit;

endmodule

`default_nettype wire

/* hw/executeStage.sv */
`default_nettype none

`include "proc_cfg.svh"

module executeStage (
  input  logic               clk,
  input  logic               arstN,
  input  pipePkg::idEx_t     idEx,
  output pipePkg::exMem_t    exMem,
  output pipePkg::redirect_t redirect
);
  import isaPkg::*;

  logic [`PROC_DATA_W-1:0] opB;
  logic [`PROC_DATA_W-1:0] result;
  logic                    aIsZero;

  // second operand is the immediate for ADDI, LD and ST
  assign opB = idEx.ctrl.useImm ? idEx.imm : idEx.b;

  always_comb begin
    case (idEx.ctrl.aluOp)
      ALU_ADD: result = idEx.a + opB;
      ALU_SUB: result = idEx.a - opB;
      ALU_AND: result = idEx.a & opB;
      ALU_XOR: result = idEx.a ^ opB;
      default: result = '0;
    endcase
  end

  assign aIsZero = (idEx.a == '0);

  // displacement is relative to the next pc
  assign redirect.taken  = idEx.valid &
                           (idEx.ctrl.isJump | (idEx.ctrl.isBranch & aIsZero));
  assign redirect.target = idEx.pc + idEx.imm;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      exMem <= '0;
    end else begin
      exMem.valid     <= idEx.valid;
      exMem.ctrl      <= idEx.ctrl;
      exMem.result    <= result;
      exMem.storeData <= idEx.b;
      exMem.dest      <= idEx.dest;
    end
  end

endmodule

`default_nettype wire

/* hw/memoryStage.sv */
`default_nettype none

`include "proc_cfg.svh"

module memoryStage (
  input  logic               clk,
  input  logic               arstN,
  input  pipePkg::exMem_t    exMem,
  output pipePkg::memWb_t    memWb,
  output pipePkg::memWrite_t stOut
);
  localparam int dmemAw = $clog2(`PROC_DMEM_DEPTH);

  logic [`PROC_DATA_W-1:0] dmem [`PROC_DMEM_DEPTH];
  logic [dmemAw-1:0]       addr;

  // word address, upper bits wrap
  assign addr = exMem.result[dmemAw-1:0];

  assign stOut.valid = exMem.valid & exMem.ctrl.memWrite;
  assign stOut.addr  = exMem.result;
  assign stOut.data  = exMem.storeData;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `PROC_DMEM_DEPTH; i++) begin
        dmem[i] <= '0;
      end
    end else if (stOut.valid) begin
      dmem[addr] <= exMem.storeData;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memWb <= '0;
    end else begin
      memWb.valid    <= exMem.valid;
      memWb.ctrl     <= exMem.ctrl;
      memWb.result   <= exMem.result;
      memWb.loadData <= dmem[addr];
      memWb.dest     <= exMem.dest;
    end
  end

endmodule

`default_nettype wire

/* hw/proc.sv */
`default_nettype none

`include "proc_cfg.svh"

module proc (
  input  logic                                 clk,
  input  logic                                 arstN,
  input  logic                                 imemWe,
  input  logic [$clog2(`PROC_IMEM_DEPTH)-1:0]  imemAddr,
  input  isaPkg::instr_t                       imemData,
  output pipePkg::regWrite_t                   wbOut,
  output pipePkg::memWrite_t                   stOut,
  output logic                                 halted,
  output logic                                 err
);
  import pipePkg::*;

  ifId_t     ifId;
  idEx_t     idEx;
  exMem_t    exMem;
  memWb_t    memWb;
  redirect_t redirect;
  srcUse_t   srcUse;
  logic      stall;

  fetchStage fetch (
    .clk      (clk),
    .arstN    (arstN),
    .imemWe   (imemWe),
    .imemAddr (imemAddr),
    .imemData (imemData),
    .stall    (stall),
    .redirect (redirect),
    .halted   (halted),
    .ifId     (ifId)
  );

  // decode also owns the register file and the writeback side
  decodeStage decode (
    .clk      (clk),
    .arstN    (arstN),
    .ifId     (ifId),
    .memWb    (memWb),
    .stall    (stall),
    .redirect (redirect),
    .idEx     (idEx),
    .srcUse   (srcUse),
    .wbOut    (wbOut),
    .halted   (halted),
    .err      (err)
  );

  hazardDetect hazard (
    .srcUse (srcUse),
    .idEx   (idEx),
    .exMem  (exMem),
    .stall  (stall)
  );

  executeStage execute (
    .clk      (clk),
    .arstN    (arstN),
    .idEx     (idEx),
    .exMem    (exMem),
    .redirect (redirect)
  );

  memoryStage memory (
    .clk   (clk),
    .arstN (arstN),
    .exMem (exMem),
    .memWb (memWb),
    .stOut (stOut)
  );

endmodule

`default_nettype wire

/* verif/procChk.sv */
`default_nettype none

module procChk (
  input logic               clk,
  input logic               arstN,
  input logic               halted,
  input logic               err,
  input pipePkg::regWrite_t wbOut,
  input pipePkg::memWrite_t stOut
);
  timeunit 1ns;
  timeprecision 100ps;

  // read by the testbench at the end of the run
  int failCnt = 0;

  // only a reset clears halted
  haltSticky: assert property (@(posedge clk) disable iff (!arstN) halted |=> halted)
    else begin
      failCnt++;
      $error("halted fell without a reset");
    end

  // core is quiet one cycle after halting
  quietAfterHalt: assert property (@(posedge clk) disable iff (!arstN)
    halted |=> !wbOut.valid && !stOut.valid)
    else begin
      failCnt++;
      $error("writeback or store seen after halt");
    end

  errHalts: assert property (@(posedge clk) disable iff (!arstN) err |-> halted)
    else begin
      failCnt++;
      $error("err high while halted is low");
    end

endmodule

`default_nettype wire

/* verif/procTb.sv */
`default_nettype none

`include "proc_cfg.svh"

module procTb;
  timeunit 1ns;
  timeprecision 100ps;
  import isaPkg::*;
  import pipePkg::*;

  localparam int numProgs = 8;
  localparam int imemAw   = $clog2(`PROC_IMEM_DEPTH);
  localparam int dmemAw   = $clog2(`PROC_DMEM_DEPTH);

  logic      clk;
  logic      arstN;
  logic      imemWe;
  logic [imemAw-1:0] imemAddr;
  instr_t    imemData;
  regWrite_t wbOut;
  memWrite_t stOut;
  logic      halted;
  logic      err;

  int seed;
  int progLen;
  logic [15:0]             prog [`PROC_IMEM_DEPTH];
  logic [`PROC_DATA_W-1:0] mReg [`PROC_REG_CNT];
  logic [`PROC_DATA_W-1:0] mMem [`PROC_DMEM_DEPTH];
  logic      expErr;
  regWrite_t expWrites [$];
  memWrite_t expStores [$];
  int writeErrs;
  int storeErrs;
  int statusErrs;
  int otherErrs;

  proc u_dut (
    .clk      (clk),
    .arstN    (arstN),
    .imemWe   (imemWe),
    .imemAddr (imemAddr),
    .imemData (imemData),
    .wbOut    (wbOut),
    .stOut    (stOut),
    .halted   (halted),
    .err      (err)
  );

  bind proc procChk chk (
    .clk    (clk),
    .arstN  (arstN),
    .halted (halted),
    .err    (err),
    .wbOut  (wbOut),
    .stOut  (stOut)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic int randBelow(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // two ADDI base loads, a random body, then HALT or an illegal word
  task automatic makeProgram(input bit endIllegal);
    int kind;
    int disp;
    logic [2:0] rd;
    progLen = 40 + randBelow(21);
    prog[0] = {OP_ADDI, 3'd0, 3'd6, 5'(randBelow(32))};
    prog[1] = {OP_ADDI, 3'd0, 3'd7, 5'(randBelow(32))};
    for (int i = 2; i < progLen - 1; i++) begin
      kind = randBelow(10);
      rd   = 3'(randBelow(6));
      // forward only, never past the last word
      disp = 1 + randBelow(3);
      if (disp > progLen - 2 - i) begin
        disp = progLen - 2 - i;
      end
      case (kind)
        0, 1, 2, 3, 4: prog[i] = {3'b110, 2'(randBelow(4)), 3'(randBelow(8)),
                                  3'(randBelow(8)), rd, 2'b00};
        5: prog[i] = {OP_ADDI, 3'(randBelow(8)), 3'(randBelow(8)), 5'(randBelow(32))};
        // r6 and r7 hold the ADDI base addresses
        6: prog[i] = {OP_LD, 2'b11, 1'(randBelow(2)), rd, 5'(randBelow(32))};
        7: prog[i] = {OP_ST, 2'b11, 1'(randBelow(2)), 3'(randBelow(8)), 5'(randBelow(32))};
        8: prog[i] = {OP_BEQZ, 3'(randBelow(8)), 8'(disp)};
        default: prog[i] = {OP_J, 11'(disp)};
      endcase
    end
    prog[progLen-1] = endIllegal ? {3'b111, 2'(randBelow(4)), 11'(randBelow(2048))} :
                                   {OP_HALT, 11'd0};
    // unused words hold HALT tagged with their address
    for (int a = progLen; a < `PROC_IMEM_DEPTH; a++) begin
      prog[a] = 16'(a[imemAw-1:0]);
    end
  endtask

  task automatic modelWrite(dest_t d, logic [`PROC_DATA_W-1:0] v);
    regWrite_t e;
    mReg[d]  = v;
    e.valid  = 1'b1;
    e.regIdx = d;
    e.data   = v;
    expWrites.push_back(e);
  endtask

  // in-order ISA model, one instruction per step
  task automatic runModel();
    logic [15:0] w;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] sum;
    memWrite_t   st;
    int pc;
    bit done;
    for (int r = 0; r < `PROC_REG_CNT; r++) begin
      mReg[r] = '0;
    end
    for (int m = 0; m < `PROC_DMEM_DEPTH; m++) begin
      mMem[m] = '0;
    end
    pc   = 0;
    done = 1'b0;
    while (!done) begin
      w   = prog[pc];
      a   = mReg[w[10:8]];
      b   = mReg[w[7:5]];
      sum = a + {{11{w[4]}}, w[4:0]};
      pc++;
      case (w[15:11])
        OP_ADD:  modelWrite(w[4:2], a + b);
        OP_SUB:  modelWrite(w[4:2], a - b);
        OP_AND:  modelWrite(w[4:2], a & b);
        OP_XOR:  modelWrite(w[4:2], a ^ b);
        OP_ADDI: modelWrite(w[7:5], sum);
        OP_LD:   modelWrite(w[7:5], mMem[sum[dmemAw-1:0]]);
        OP_ST: begin
          mMem[sum[dmemAw-1:0]] = b;
          st.valid = 1'b1;
          st.addr  = sum;
          st.data  = b;
          expStores.push_back(st);
        end
        // displacements count from the next word
        OP_BEQZ: if (a == '0) pc += int'($signed(w[7:0]));
        OP_J:    pc += int'($signed(w[10:0]));
        OP_HALT: begin
          expErr = 1'b0;
          done   = 1'b1;
        end
        default: begin
          expErr = 1'b1;
          done   = 1'b1;
        end
      endcase
    end
  endtask

  task automatic loadProgram();
    @(posedge clk);
    #2;
    arstN  = 1'b0;
    imemWe = 1'b1;
    for (int a = 0; a < `PROC_IMEM_DEPTH; a++) begin
      imemAddr = a[imemAw-1:0];
      imemData = instr_t'(prog[a]);
      @(posedge clk);
      #2;
    end
    imemWe = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    arstN = 1'b1;
  endtask

  task automatic checkWrite(regWrite_t got);
    regWrite_t exp;
    if (expWrites.size() == 0) begin
      $display("register write to r%0d arrived with none left to expect", got.regIdx);
      writeErrs++;
    end else begin
      exp = expWrites.pop_front();
      if (got !== exp) begin
        $display("error wbOut: got reg %h data %h, expected reg %h data %h",
                 got.regIdx, got.data, exp.regIdx, exp.data);
        writeErrs++;
      end
    end
  endtask

  task automatic checkStore(memWrite_t got);
    memWrite_t exp;
    if (expStores.size() == 0) begin
      $display("store to address %h arrived with none left to expect", got.addr);
      storeErrs++;
    end else begin
      exp = expStores.pop_front();
      if (got !== exp) begin
        $display("error stOut: got addr %h data %h, expected addr %h data %h",
                 got.addr, got.data, exp.addr, exp.data);
        storeErrs++;
      end
    end
  endtask

  task automatic checkFlag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("error %s: got %h, expected %h", name, got, exp);
      statusErrs++;
    end
  endtask

  // outputs settle after the rising edge, sample them mid cycle
  task automatic watchOutputs();
    forever begin
      @(negedge clk);
      if (arstN) begin
        if (wbOut.valid) checkWrite(wbOut);
        if (stOut.valid) checkStore(stOut);
      end
    end
  endtask

  initial begin
    int cycles;
    int limit;
    int total;
    seed       = 32'h38db;
    arstN      = 1'b0;
    imemWe     = 1'b0;
    imemAddr   = '0;
    imemData   = '0;
    writeErrs  = 0;
    storeErrs  = 0;
    statusErrs = 0;
    otherErrs  = 0;
    repeat (2) @(posedge clk);
    #2;
    arstN = 1'b1;
    @(negedge clk);
    checkFlag("halted", halted, 1'b0);
    checkFlag("err", err, 1'b0);
    checkFlag("wbOut.valid", wbOut.valid, 1'b0);
    checkFlag("stOut.valid", stOut.valid, 1'b0);
    fork
      watchOutputs();
    join_none
    for (int p = 0; p < numProgs; p++) begin
      makeProgram(p % 4 == 3);
      runModel();
      loadProgram();
      limit  = progLen * 4 + 20;
      cycles = 0;
      while (!halted && cycles < limit) begin
        @(negedge clk);
        cycles++;
      end
      if (!halted) begin
        $display("timeout: program %0d did not halt within %0d cycles", p, limit);
        otherErrs++;
        break;
      end
      repeat (4) @(negedge clk);
      checkFlag("halted", halted, 1'b1);
      checkFlag("err", err, expErr);
      @(posedge clk);
      #2;
      if (expWrites.size() != 0 || expStores.size() != 0) begin
        $display("program %0d ended with %0d register writes and %0d stores missing",
                 p, expWrites.size(), expStores.size());
        otherErrs++;
      end
      expWrites.delete();
      expStores.delete();
    end
    total = writeErrs + storeErrs + statusErrs + otherErrs + u_dut.chk.failCnt;
    $display("errors: wbOut %0d, stOut %0d, status %0d, other %0d, assertions %0d",
             writeErrs, storeErrs, statusErrs, otherErrs, u_dut.chk.failCnt);
    if (total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+include
hw/isaPkg.sv
hw/pipePkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/hazardDetect.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/proc.sv
verif/procChk.sv
verif/procTb.sv

/* Makefile */
# Verilator build and run for the five-stage core

VERILATOR ?= verilator
TOP       ?= procTb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)

PASS_MSG := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG TIMESCALE VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
